/* bench/exec_slice_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_slice_tb;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam int         WAIT_LIMIT = 200; // cycles per check

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [63:0] pc;
    logic        bubble;
    logic        flush;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;
    logic        redirect;
    logic [63:0] redirect_pc;

    logic [63:0] ref_regs [32]; // reference register file
    logic [63:0] cur_pc;
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_data [$];
    logic [63:0] exp_pc [$];
    logic [4:0]  obs_rd [$];
    logic [63:0] obs_data [$];
    logic [63:0] obs_pc [$];
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int unsigned seed_dummy;

    exec_slice_top u_exec_slice_top (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .bubble_i      (bubble),
        .flush_i       (flush),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // pulses are stable mid-cycle
    always @(negedge clk) begin
        if (wb_valid) begin
            obs_rd.push_back(wb_rd);
            obs_data.push_back(wb_data);
        end
        if (redirect) begin
            obs_pc.push_back(redirect_pc);
        end
    end

    function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // RV64I integer rules with shift amount from the low 6 bits
    function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[5:0];
            3'd2: return {63'd0, $signed(a) < $signed(b)};
            3'd3: return {63'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[5:0];
                end
                return a >> b[5:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [63:0] a,
                                        input logic [63:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic issue(input logic [31:0] word);
        instr_valid = 1'b1;
        instr       = word;
        pc          = cur_pc;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        cur_pc      = cur_pc + 64'd4;
    endtask

    task automatic retire(input logic [4:0] rd, input logic [63:0] val);
        if (rd != 5'd0) begin
            ref_regs[rd] = val;
            exp_rd.push_back(rd);
            exp_data.push_back(val);
        end
    endtask

    task automatic op_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
        logic [63:0] val;
        val = alu_ref(f3, alt, ref_regs[rs1], ref_regs[rs2]);
        issue(enc_r(alt, rs2, rs1, f3, rd));
        retire(rd, val);
    endtask

    task automatic op_i(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rd,
                        input logic [4:0] rs1);
        logic [63:0] val;
        val = alu_ref(f3, f3 == 3'd5 && imm[10], ref_regs[rs1], {{52{imm[11]}}, imm});
        issue(enc_i(imm, rs1, f3, rd, OPC_IMM));
        retire(rd, val);
    endtask

    task automatic op_upper(input logic is_auipc, input logic [19:0] imm, input logic [4:0] rd);
        logic [63:0] val;
        val = {{32{imm[19]}}, imm, 12'h000};
        if (is_auipc) begin
            val = val + cur_pc;
        end
        issue({imm, rd, is_auipc ? OPC_AUIPC : OPC_LUI});
        retire(rd, val);
    endtask

    // the next slot is squashed when taken, else it executes
    task automatic after_jump(input logic taken, input logic [63:0] target);
        if (taken) begin
            exp_pc.push_back(target);
            issue(enc_i(12'h7ff, 5'd9, 3'd0, 5'd9, OPC_IMM));
            cur_pc = target;
        end else begin
            op_i(3'd0, 12'h7ff, 5'd9, 5'd9);
        end
    endtask

    task automatic op_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [12:0] off;
        logic        taken;
        logic [63:0] target;
        off    = 13'($urandom()) & 13'h1ffc;
        taken  = branch_ref(f3, ref_regs[rs1], ref_regs[rs2]);
        target = cur_pc + {{51{off[12]}}, off};
        issue(enc_b(off, rs2, rs1, f3));
        after_jump(taken, target);
    endtask

    task automatic op_jal(input logic [4:0] rd);
        logic [20:0] off;
        logic [63:0] link;
        logic [63:0] target;
        off    = 21'($urandom()) & 21'h1ffffc;
        link   = cur_pc + 64'd4;
        target = cur_pc + {{43{off[20]}}, off};
        issue(enc_j(off, rd));
        retire(rd, link);
        after_jump(1'b1, target);
    endtask

    task automatic op_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [63:0] sum;
        logic [63:0] link;
        sum  = ref_regs[rs1] + {{52{imm[11]}}, imm};
        link = cur_pc + 64'd4;
        issue(enc_i(imm, rs1, 3'd0, rd, OPC_JALR));
        retire(rd, link);
        after_jump(1'b1, {sum[63:1], 1'b0});
    endtask

    task automatic load_rand(input logic [4:0] rd);
        op_upper(1'b0, 20'($urandom()), rd);
        op_i(3'd0, 12'($urandom()), rd, rd);
        op_i(3'd1, 12'd32, rd, rd);
        op_upper(1'b0, 20'($urandom()), 5'd3); // x3 scratch
        op_i(3'd0, 12'($urandom()), 5'd3, 5'd3);
        op_r(3'd4, 1'b0, rd, rd, 5'd3);
    endtask

    task automatic check_results(input string name);
        int waited;
        int n;
        waited = 0;
        while ((obs_rd.size() < exp_rd.size() || obs_pc.size() < exp_pc.size()) &&
               waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (obs_rd.size() < exp_rd.size() || obs_pc.size() < exp_pc.size()) begin
            $display("timeout in %s: expected writebacks or redirects never came", name);
            test_errors++;
        end
        if (obs_rd.size() != exp_rd.size()) begin
            $display("mismatch %s writeback count: expected %0d actual %0d",
                     name, exp_rd.size(), obs_rd.size());
            test_errors++;
        end
        n = (obs_rd.size() < exp_rd.size()) ? obs_rd.size() : exp_rd.size();
        for (int i = 0; i < n; i++) begin
            if (obs_rd[i] !== exp_rd[i] || obs_data[i] !== exp_data[i]) begin
                $display("mismatch %s writeback %0d: expected x%0d=%h actual x%0d=%h",
                         name, i, exp_rd[i], exp_data[i], obs_rd[i], obs_data[i]);
                test_errors++;
            end
        end
        if (obs_pc.size() != exp_pc.size()) begin
            $display("mismatch %s redirect count: expected %0d actual %0d",
                     name, exp_pc.size(), obs_pc.size());
            test_errors++;
        end
        n = (obs_pc.size() < exp_pc.size()) ? obs_pc.size() : exp_pc.size();
        for (int i = 0; i < n; i++) begin
            if (obs_pc[i] !== exp_pc[i]) begin
                $display("mismatch %s redirect %0d: expected %h actual %h",
                         name, i, exp_pc[i], obs_pc[i]);
                test_errors++;
            end
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
        exp_rd.delete();
        exp_data.delete();
        exp_pc.delete();
        obs_rd.delete();
        obs_data.delete();
        obs_pc.delete();
    endtask

    task automatic test_alu();
        for (int round = 0; round < 4; round++) begin
            load_rand(5'd1);
            load_rand(5'd2);
            for (int k = 0; k < 8; k++) begin
                op_r(3'(k), 1'b0, 5'(10 + k), 5'd1, 5'd2);
                if (k != 1 && k != 5) begin
                    op_i(3'(k), 12'($urandom()), 5'(20 + k), 5'd1);
                end
            end
            op_r(3'd0, 1'b1, 5'd18, 5'd1, 5'd2); // sub
            op_r(3'd5, 1'b1, 5'd19, 5'd1, 5'd2); // sra
            op_i(3'd1, {6'd0, 6'($urandom())}, 5'd21, 5'd1);
            op_i(3'd5, {6'd0, 6'($urandom())}, 5'd25, 5'd1);
            op_i(3'd5, {6'b010000, 6'($urandom())}, 5'd28, 5'd2); // srai
            op_upper(1'b0, 20'($urandom()), 5'd29);
            op_upper(1'b1, 20'($urandom()), 5'd30);
        end
        check_results("alu");
    endtask

    task automatic test_forwarding();
        logic [2:0] f3;
        logic       alt;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        load_rand(5'd4);
        load_rand(5'd5);
        for (int k = 0; k < 32; k++) begin
            rd  = 5'd4 + 5'($urandom_range(3)); // small register set for dense dependencies
            rs1 = 5'd4 + 5'($urandom_range(3));
            rs2 = 5'd4 + 5'($urandom_range(3));
            f3  = 3'($urandom());
            alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'($urandom()) : 1'b0;
            if (k % 4 == 3) begin
                op_i(3'd0, 12'($urandom()), rd, rs1);
            end else begin
                op_r(f3, alt, rd, rs1, rs2);
            end
        end
        check_results("forwarding");
    endtask

    task automatic test_branches();
        op_i(3'd0, 12'hffb, 5'd1, 5'd0); // -5
        op_i(3'd0, 12'd3, 5'd2, 5'd0);
        op_i(3'd0, 12'd3, 5'd3, 5'd0);
        for (int k = 0; k < 8; k++) begin
            if (k != 2 && k != 3) begin
                op_branch(3'(k), 5'd2, 5'd3);
                op_branch(3'(k), 5'd1, 5'd2);
                op_branch(3'(k), 5'd2, 5'd1);
            end
        end
        op_jal(5'd11);
        op_jal(5'd0);
        op_i(3'd0, 12'h124, 5'd13, 5'd2); // odd base for jalr
        op_jalr(5'd12, 5'd13, 12'h030);
        op_i(3'd0, 12'd1, 5'd10, 5'd12);
        check_results("branches");
    endtask

    task automatic test_bubble();
        logic [63:0] val;
        load_rand(5'd14);
        op_i(3'd0, 12'd7, 5'd15, 5'd14);
        val         = ref_regs[15] + 64'd1;
        instr_valid = 1'b1; // next instr held upstream while stalled
        instr       = enc_i(12'd1, 5'd15, 3'd0, 5'd16, OPC_IMM);
        pc          = cur_pc;
        bubble      = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        if (obs_rd.size() != exp_rd.size() - 1) begin
            $display("mismatch bubble writebacks during stall: expected %0d actual %0d",
                     exp_rd.size() - 1, obs_rd.size());
            test_errors++;
        end
        bubble = 1'b0;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        cur_pc      = cur_pc + 64'd4;
        retire(5'd16, val);
        check_results("bubble");
    endtask

    task automatic issue_flushed(input logic [31:0] word, input logic held);
        instr_valid = 1'b1;
        instr       = word;
        pc          = cur_pc;
        flush       = !held;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        bubble      = held;
        flush       = held;
        if (held) begin
            @(posedge clk);
            #1;
        end
        bubble = 1'b0;
        flush  = 1'b0;
        cur_pc = cur_pc + 64'd4;
    endtask

    task automatic test_flush_x0();
        op_i(3'd0, 12'd100, 5'd17, 5'd0);
        issue_flushed(enc_i(12'd1, 5'd17, 3'd0, 5'd17, OPC_IMM), 1'b1);
        issue_flushed(enc_i(12'd2, 5'd17, 3'd0, 5'd17, OPC_IMM), 1'b0);
        op_i(3'd0, 12'd5, 5'd0, 5'd0);
        op_r(3'd0, 1'b0, 5'd0, 5'd17, 5'd17);
        op_r(3'd0, 1'b0, 5'd18, 5'd0, 5'd17);
        op_r(3'd6, 1'b0, 5'd19, 5'd0, 5'd0);
        op_i(3'd0, 12'd3, 5'd20, 5'd17); // x17 still 100
        check_results("flush_x0");
    endtask

    initial begin
        seed_dummy   = $urandom(32'hff5d178b);
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = 32'h0000_0000;
        pc           = 64'd0;
        bubble       = 1'b0;
        flush        = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        ref_regs     = '{default: 64'd0};
        cur_pc       = 64'h0000_0000_8000_0000;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_alu();
        test_forwarding();
        test_branches();
        test_bubble();
        test_flush_x0();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module exec_slice_tb -f src.f -o exec_slice_sim &&
out=$(./obj_dir/exec_slice_sim) &&
echo "$out" &&
echo "$out" | grep -q "PASS: all tests" ||
{ echo "simulation failed"; exit 1; }

/* source/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN = 64;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B // lui
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JAL,
        BR_JALR
    } br_op_e;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef struct packed {
        logic            valid;
        alu_op_e         alu_op;
        br_op_e          br_op;
        logic            sel_a_pc;  // operand a is pc
        logic            sel_b_imm; // operand b is imm
        logic            write_rd;
        logic [4:0]      rs1_addr;
        logic [4:0]      rs2_addr;
        logic [4:0]      rd_addr;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic            write_rd;
        logic [4:0]      rd_addr;
        logic [XLEN-1:0] result; // alu value or pc+4
        logic            taken;
        logic [XLEN-1:0] target;
    } ex_wb_t;

endpackage

`default_nettype wire

/* source/exec_slice_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_slice_top import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            bubble_i,
    input  logic            flush_i,
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            squash;
    id_ex_t          id_d;
    id_ex_t          ex_q;
    ex_wb_t          ex_res;
    ex_wb_t          wb_q;

    instr_decode u_instr_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .id_o          (id_d)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_valid_o),
        .wr_addr_i  (wb_rd_o),
        .wr_data_i  (wb_data_o)
    );

    id_ex_reg u_id_ex_reg (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .squash_i (squash),
        .bubble_i (bubble_i),
        .id_i     (id_d),
        .ex_o     (ex_q)
    );

    exec_unit u_exec_unit (
        .ex_i     (ex_q),
        .bubble_i (bubble_i),
        .fwd_i    (wb_q),
        .res_o    (ex_res),
        .squash_o (squash)
    );

    result_stage u_result_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .res_i         (ex_res),
        .wb_o          (wb_q),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import core_pkg::*; (
    input  id_ex_t ex_i,
    input  logic   bubble_i,
    input  ex_wb_t fwd_i,
    output ex_wb_t res_o,
    output logic   squash_o
);

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] alu_val;
    logic [XLEN-1:0] jalr_sum;
    logic [XLEN-1:0] target;
    logic            is_jump;
    logic            cond;

    // forward from the result stage on a matching non-zero rd
    assign fwd_rs1 = fwd_i.write_rd && (fwd_i.rd_addr != 5'd0) &&
                     (fwd_i.rd_addr == ex_i.rs1_addr);
    assign fwd_rs2 = fwd_i.write_rd && (fwd_i.rd_addr != 5'd0) &&
                     (fwd_i.rd_addr == ex_i.rs2_addr);
    assign rs1_val = fwd_rs1 ? fwd_i.result : ex_i.rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_i.result : ex_i.rs2_data;

    assign op_a  = ex_i.sel_a_pc  ? ex_i.pc  : rs1_val;
    assign op_b  = ex_i.sel_b_imm ? ex_i.imm : rs2_val;
    assign shamt = op_b[5:0];

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    alu_val = op_a + op_b;
            ALU_SUB:    alu_val = op_a - op_b;
            ALU_AND:    alu_val = op_a & op_b;
            ALU_OR:     alu_val = op_a | op_b;
            ALU_XOR:    alu_val = op_a ^ op_b;
            ALU_SLL:    alu_val = op_a << shamt;
            ALU_SRL:    alu_val = op_a >> shamt;
            ALU_SRA:    alu_val = $unsigned($signed(op_a) >>> shamt);
            ALU_SLT:    alu_val = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_val = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_PASS_B: alu_val = op_b;
            default:    alu_val = '0;
        endcase
    end

    always_comb begin
        case (ex_i.br_op)
            BR_EQ:   cond = (rs1_val == rs2_val);
            BR_NE:   cond = (rs1_val != rs2_val);
            BR_LT:   cond = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:   cond = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:  cond = (rs1_val < rs2_val);
            BR_GEU:  cond = (rs1_val >= rs2_val);
            BR_JAL:  cond = 1'b1;
            BR_JALR: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign is_jump  = (ex_i.br_op == BR_JAL) || (ex_i.br_op == BR_JALR);
    assign jalr_sum = rs1_val + ex_i.imm;
    assign target   = (ex_i.br_op == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                              : ex_i.pc + ex_i.imm;

    always_comb begin
        if (bubble_i) begin
            // keep last result visible for forwarding, but never write it again
            res_o       = fwd_i;
            res_o.valid = 1'b0;
            res_o.taken = 1'b0;
        end else begin
            res_o.valid    = ex_i.valid;
            res_o.write_rd = ex_i.valid && ex_i.write_rd;
            res_o.rd_addr  = ex_i.rd_addr;
            res_o.result   = is_jump ? ex_i.pc + 64'd4 : alu_val; // link value
            res_o.taken    = ex_i.valid && cond;
            res_o.target   = target;
        end
    end

    assign squash_o = ex_i.valid && cond && !bubble_i;

endmodule

`default_nettype wire

/* source/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import core_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   flush_i,
    input  logic   squash_i,
    input  logic   bubble_i,
    input  id_ex_t id_i,
    output id_ex_t ex_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_o <= '0;
        end else if (flush_i) begin
            ex_o <= '0;
        end else if (squash_i) begin
            ex_o <= '0; // younger instr behind a taken branch
        end else if (bubble_i) begin
            ex_o <= ex_o; // hold
        end else begin
            ex_o <= id_i;
        end
    end

endmodule

`default_nettype wire

/* source/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode import core_pkg::*; (
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    output id_ex_t          id_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic            legal;
    logic            has_rd;
    logic            sel_a_pc;
    logic            sel_b_imm;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    br_op_e          br_op;

    // map funct3 to alu op with alt picking sub or sra
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd     = instr_i[11:7];

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {{(XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_b = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        legal     = 1'b0;
        has_rd    = 1'b0;
        sel_a_pc  = 1'b0;
        sel_b_imm = 1'b0;
        imm       = '0;
        alu_op    = ALU_ADD;
        br_op     = BR_NONE;
        case (opcode)
            OPC_OP: begin
                legal  = (funct7 == 7'b0000000) ||
                         (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                has_rd = 1'b1;
                alu_op = alu_from_funct(funct3, funct7[5]);
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    legal = (instr_i[31:26] == 6'b000000);
                end else if (funct3 == 3'b101) begin
                    legal = (instr_i[31:26] == 6'b000000) || (instr_i[31:26] == 6'b010000);
                end else begin
                    legal = 1'b1;
                end
                has_rd    = 1'b1;
                sel_b_imm = 1'b1;
                imm       = imm_i;
                alu_op    = alu_from_funct(funct3, instr_i[30] && funct3 == 3'b101);
            end
            OPC_LUI: begin
                legal     = 1'b1;
                has_rd    = 1'b1;
                sel_b_imm = 1'b1;
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                legal     = 1'b1;
                has_rd    = 1'b1;
                sel_a_pc  = 1'b1;
                sel_b_imm = 1'b1;
                imm       = imm_u;
            end
            OPC_JAL: begin
                legal  = 1'b1;
                has_rd = 1'b1;
                imm    = imm_j;
                br_op  = BR_JAL;
            end
            OPC_JALR: begin
                legal  = (funct3 == 3'b000);
                has_rd = 1'b1;
                imm    = imm_i;
                br_op  = BR_JALR;
            end
            OPC_BRANCH: begin
                legal = 1'b1;
                imm   = imm_b;
                case (funct3)
                    3'b000:  br_op = BR_EQ;
                    3'b001:  br_op = BR_NE;
                    3'b100:  br_op = BR_LT;
                    3'b101:  br_op = BR_GE;
                    3'b110:  br_op = BR_LTU;
                    3'b111:  br_op = BR_GEU;
                    default: legal = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        id_o.valid     = instr_valid_i && legal;
        id_o.alu_op    = alu_op;
        id_o.br_op     = br_op;
        id_o.sel_a_pc  = sel_a_pc;
        id_o.sel_b_imm = sel_b_imm;
        id_o.write_rd  = instr_valid_i && legal && has_rd && (rd != 5'd0); // x0 never written
        id_o.rs1_addr  = rs1_addr_o;
        id_o.rs2_addr  = rs2_addr_o;
        id_o.rd_addr   = rd;
        id_o.rs1_data  = rs1_data_i;
        id_o.rs2_data  = rs2_data_i;
        id_o.imm       = imm;
        id_o.pc        = pc_i;
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  logic            we_i,
    input  logic [4:0]      wr_addr_i,
    input  logic [XLEN-1:0] wr_data_i
);

    logic [XLEN-1:0] regs [1:31]; // no storage for x0
    logic            rs1_bypass;
    logic            rs2_bypass;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wr_addr_i != 5'd0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write-through so decode sees the value landing this cycle
    assign rs1_bypass = we_i && (wr_addr_i == rs1_addr_i);
    assign rs2_bypass = we_i && (wr_addr_i == rs2_addr_i);

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 :
                        rs1_bypass           ? wr_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 :
                        rs2_bypass           ? wr_data_i : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* source/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage import core_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  ex_wb_t          res_i,
    output ex_wb_t          wb_o,
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_o.valid    <= 1'b0;
            wb_o.write_rd <= 1'b0;
            wb_o.taken    <= 1'b0;
        end else begin
            wb_o.valid    <= res_i.valid;
            wb_o.write_rd <= res_i.write_rd;
            wb_o.taken    <= res_i.taken;
        end
    end

    // payload, qualified by the flags above
    always_ff @(posedge clk_i) begin
        wb_o.rd_addr <= res_i.rd_addr;
        wb_o.result  <= res_i.result;
        wb_o.target  <= res_i.target;
    end

    assign wb_valid_o    = wb_o.valid && wb_o.write_rd;
    assign wb_rd_o       = wb_o.rd_addr;
    assign wb_data_o     = wb_o.result;
    assign redirect_o    = wb_o.valid && wb_o.taken; // one cycle per taken branch
    assign redirect_pc_o = wb_o.target;

endmodule

`default_nettype wire

/* src.f */
source/core_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/id_ex_reg.sv
source/exec_unit.sv
source/result_stage.sv
source/exec_slice_top.sv
bench/exec_slice_tb.sv
